//--- design/mrd_bank_mem.sv
`timescale 1ns/1ps
`default_nettype none
`include "mrd_defines.svh"

module mrd_bank_mem
(
	input  wire                    clk,
	input  wire                    rst_n,
	input  wire                    wr_en,
	input  wire [`MRD_W_ROW-1:0]   wr_row,
	input  wire [2:0]              wr_bank,
	input  wire [`MRD_W_DATA-1:0]  wr_data,
	input  wire                    rd_en,
	input  wire [`MRD_W_ROW-1:0]   rd_row,
	input  wire [2:0]              rd_bank,
	output logic                   mem_valid,
	output logic [`MRD_W_DATA-1:0] mem_data
);

	// rows for the largest frame, 586 per bank
	localparam int N_ROW = ((1 << `MRD_W_ADDR) + `MRD_N_BANK - 1) / `MRD_N_BANK;

	logic [`MRD_N_BANK-1:0]  rd_sel;
	logic [`MRD_W_DATA-1:0]  bank_q [`MRD_N_BANK];
	logic [`MRD_W_DATA-1:0]  rd_mux;

	// one row array per bank
	for (genvar b = 0; b < `MRD_N_BANK; b++)
	begin : g_bank
		logic [`MRD_W_DATA-1:0] ram [N_ROW];

		always_ff @(posedge clk)
		begin
			if (wr_en && (wr_bank == 3'(b)))
				ram[wr_row] <= wr_data;
		end

		// all banks see the same row
		assign bank_q[b] = ram[rd_row];
	end

	// one-hot bank enable, and-or mux
	always_comb
	begin
		rd_sel = '0;
		rd_mux = '0;
		for (int b = 0; b < `MRD_N_BANK; b++)
		begin
			rd_sel[b] = rd_en && (rd_bank == 3'(b));
			rd_mux    = rd_mux | (bank_q[b] & {`MRD_W_DATA{rd_sel[b]}});
		end
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
			mem_valid <= 1'b0;
		else
			mem_valid <= rd_en;
	end

	// read data register
	always_ff @(posedge clk)
	begin
		mem_data <= rd_mux;
	end

	// a bank index of 7 from the divider leaves rd_sel empty
	a_rd_onehot: assert property (@(posedge clk) disable iff (!rst_n)
		rd_en |-> $onehot(rd_sel));

endmodule

`default_nettype wire

//--- design/mrd_ctrl_fsm.sv
`timescale 1ns/1ps
`default_nettype none
`include "mrd_defines.svh"

module mrd_ctrl_fsm
(
	input  wire                                    clk,
	input  wire                                    rst_n,
	input  wire mrd_pkg::radix_t [0:`MRD_N_STAGE-1] nf,
	input  wire                                    sink_valid,
	input  wire                                    sink_sop,
	input  wire [`MRD_W_DATA-1:0]                  sink_data,
	input  wire [`MRD_W_ADDR:0]                    n_points,
	input  wire                                    source_end,
	output mrd_pkg::mrd_state_e                    state,
	output logic                                   cfg_load,
	output logic                                   wr_en,
	output logic [`MRD_W_ADDR-1:0]                 wr_addr,
	output logic [`MRD_W_DATA-1:0]                 wr_data
);

	// next index to write while in sink
	logic [`MRD_W_ADDR-1:0] wr_idx;
	logic                   sop_accept;
	logic                   single_point;
	logic                   last_write;

	// frame start only from idle
	assign sop_accept = (state == mrd_pkg::IDLE) && sink_valid && sink_sop;

	// radices latched by the address counter on this strobe
	assign cfg_load = sop_accept;

	// all radices 1, the sop sample is the whole frame
	// n_points is not loaded yet on that cycle
	always_comb
	begin
		single_point = 1'b1;
		for (int k = 0; k < `MRD_N_STAGE; k++)
		begin
			if (nf[k] != 3'd1)
				single_point = 1'b0;
		end
	end

	// sop sample is index 0
	assign wr_en   = sop_accept || ((state == mrd_pkg::SINK) && sink_valid);
	assign wr_addr = (state == mrd_pkg::SINK) ? wr_idx : '0;

	// write of index n_points - 1
	assign last_write = (state == mrd_pkg::SINK) && sink_valid
		&& ({1'b0, wr_idx} == (n_points - 1'b1));

	// data one cycle behind, lined up with the write divider output
	always_ff @(posedge clk)
	begin
		wr_data <= sink_data;
	end

	// phase sequencing
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			state  <= mrd_pkg::IDLE;
			wr_idx <= '0;
		end
		else
		begin
			case (state)
				mrd_pkg::IDLE:
				begin
					if (sop_accept)
					begin
						wr_idx <= {{(`MRD_W_ADDR-1){1'b0}}, 1'b1};
						state  <= single_point ? mrd_pkg::SOURCE : mrd_pkg::SINK;
					end
				end
				mrd_pkg::SINK:
				begin
					// gaps between samples simply hold the index
					if (sink_valid)
					begin
						wr_idx <= wr_idx + 1'b1;
						if (last_write)
							state <= mrd_pkg::SOURCE;
					end
				end
				mrd_pkg::SOURCE:
				begin
					// sink strobes ignored here
					if (source_end)
						state <= mrd_pkg::IDLE;
				end
				default:
				begin
					state <= mrd_pkg::IDLE;
				end
			endcase
		end
	end

	// n_points comes from the address counter, loaded on the sop cycle
	a_wr_idx_range: assert property (@(posedge clk) disable iff (!rst_n)
		((state == mrd_pkg::SINK) && sink_valid) |-> ({1'b0, wr_idx} < n_points));

endmodule

`default_nettype wire

//--- design/mrd_digit_rev_addr.sv
`timescale 1ns/1ps
`default_nettype none
`include "mrd_defines.svh"

module mrd_digit_rev_addr
(
	input  wire                                    clk,
	input  wire                                    rst_n,
	input  wire                                    cfg_load,
	input  wire mrd_pkg::radix_t [0:`MRD_N_STAGE-1] nf,
	input  wire                                    rd_start,
	output logic [`MRD_W_ADDR:0]                   n_points,
	output logic [`MRD_W_ADDR-1:0]                 rd_addr,
	output logic                                   rd_addr_valid
);

	localparam logic [`MRD_W_ADDR:0] PT_ONE = 1;

	// frame configuration
	mrd_pkg::radix_t [0:`MRD_N_STAGE-1]     radix_r;
	logic [0:`MRD_N_STAGE-1][`MRD_W_ADDR:0] stride_c;
	logic [0:`MRD_N_STAGE-1][`MRD_W_ADDR:0] stride_r;
	logic [`MRD_W_ADDR:0]                   n_points_c;

	// read counter, c0 fastest
	mrd_pkg::radix_t [0:`MRD_N_STAGE-1] digit;
	mrd_pkg::radix_t [0:`MRD_N_STAGE-1] digit_next;
	logic                               carry;
	logic [`MRD_W_ADDR:0]               addr_next;
	logic [`MRD_W_ADDR:0]               issued;
	logic                               nf_ok;

	// stride_k = nf[k+1] * ... * nf[5]
	always_comb
	begin
		stride_c[`MRD_N_STAGE-1] = PT_ONE;
		for (int k = `MRD_N_STAGE - 2; k >= 0; k--)
		begin
			stride_c[k] = stride_c[k+1] * nf[k+1];
		end
		// point count is one more stage up
		n_points_c = stride_c[0] * nf[0];
	end

	// config held for the whole frame
	always_ff @(posedge clk)
	begin
		if (cfg_load)
		begin
			radix_r  <= nf;
			stride_r <= stride_c;
			n_points <= n_points_c;
		end
	end

	// ripple carry through the digits
	// and weighted sum of the next digit set
	always_comb
	begin
		carry     = 1'b1;
		addr_next = '0;
		for (int k = 0; k < `MRD_N_STAGE; k++)
		begin
			if (carry && (digit[k] == (radix_r[k] - 1'b1)))
			begin
				// wrap, carry moves up
				digit_next[k] = '0;
			end
			else if (carry)
			begin
				digit_next[k] = digit[k] + 1'b1;
				carry         = 1'b0;
			end
			else
			begin
				digit_next[k] = digit[k];
			end
			addr_next = addr_next + digit_next[k] * stride_r[k];
		end
	end

	// one address per cycle for n_points cycles
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			rd_addr_valid <= 1'b0;
			issued        <= '0;
			digit         <= '0;
		end
		else if (rd_start)
		begin
			rd_addr_valid <= 1'b1;
			issued        <= PT_ONE;
			digit         <= '0;
		end
		else if (rd_addr_valid)
		begin
			if (issued == n_points)
			begin
				rd_addr_valid <= 1'b0;
			end
			else
			begin
				issued <= issued + 1'b1;
				digit  <= digit_next;
			end
		end
	end

	// address word, first one is always 0
	always_ff @(posedge clk)
	begin
		if (rd_start)
			rd_addr <= '0;
		else if (rd_addr_valid && (issued != n_points))
			rd_addr <= addr_next[`MRD_W_ADDR-1:0];
	end

	// radix fields legal when a frame opens
	always_comb
	begin
		nf_ok = 1'b1;
		for (int k = 0; k < `MRD_N_STAGE; k++)
		begin
			if ((nf[k] < 3'd1) || (nf[k] > 3'd5))
				nf_ok = 1'b0;
		end
	end

	a_nf_range: assert property (@(posedge clk) disable iff (!rst_n)
		cfg_load |-> nf_ok);

	// digit reversal stays a permutation of 0 .. n_points - 1
	a_rd_addr_range: assert property (@(posedge clk) disable iff (!rst_n)
		rd_addr_valid |-> ({1'b0, rd_addr} < n_points));

endmodule

`default_nettype wire

//--- design/mrd_divider_7.sv
`timescale 1ns/1ps
`default_nettype none
`include "mrd_defines.svh"

module mrd_divider_7
(
	input  wire                    clk,
	input  wire                    rst_n,
	input  wire [`MRD_W_ADDR-1:0]  addr,
	input  wire                    addr_valid,
	output logic [`MRD_W_ROW-1:0]  row,
	output logic [2:0]             bank,
	output logic                   bank_valid
);

	// floor(2^13 / 7)
	// estimate is the true quotient or one short for 12-bit input
	localparam int                     RECIP_SHIFT = 13;
	localparam logic [10:0]            RECIP       = 11'd1170;
	localparam logic [`MRD_W_ADDR-1:0] SEVEN       = 7;

	logic [`MRD_W_ADDR+10:0] prod;
	logic [`MRD_W_ROW-1:0]   q_est;
	logic [`MRD_W_ADDR-1:0]  r_est;
	logic [`MRD_W_ADDR-1:0]  r_sub;
	logic                    need_fix;
	logic [`MRD_W_ROW-1:0]   q_fix;
	logic [2:0]              r_fix;

	// reciprocal multiply
	assign prod  = addr * RECIP;
	assign q_est = prod[RECIP_SHIFT +: `MRD_W_ROW];

	// remainder lands in 0 .. 13
	assign r_est = addr - q_est * SEVEN;
	assign r_sub = r_est - SEVEN;

	// single correction step
	assign need_fix = (r_est >= SEVEN);
	assign q_fix    = q_est + {{(`MRD_W_ROW-1){1'b0}}, need_fix};
	assign r_fix    = need_fix ? r_sub[2:0] : r_est[2:0];

	always_ff @(posedge clk)
	begin
		if (!rst_n)
			bank_valid <= 1'b0;
		else
			bank_valid <= addr_valid;
	end

	// row is the quotient, bank the remainder
	always_ff @(posedge clk)
	begin
		row  <= q_fix;
		bank <= r_fix;
	end

endmodule

`default_nettype wire

//--- design/mrd_fsm_source.sv
`timescale 1ns/1ps
`default_nettype none
`include "mrd_defines.svh"

module mrd_fsm_source
(
	input  wire                      clk,
	input  wire                      rst_n,
	input  wire mrd_pkg::mrd_state_e state,
	input  wire [`MRD_W_ADDR:0]      n_points,
	input  wire                      mem_valid,
	input  wire [`MRD_W_DATA-1:0]    mem_data,
	output logic                     rd_start,
	output logic                     src_valid,
	output logic                     src_sop,
	output logic                     src_eop,
	output logic [`MRD_W_DATA-1:0]   src_data,
	output logic                     source_end
);

	localparam int W_WAIT = $clog2(`MRD_SRC_WAIT + 1);
	localparam logic [W_WAIT-1:0] WAIT_MAX = `MRD_SRC_WAIT;

	logic [W_WAIT-1:0]    cnt_wait;
	logic                 wait_done_r;
	logic                 in_source;
	logic                 mem_valid_r;
	logic [`MRD_W_ADDR:0] cnt_out;

	assign in_source = (state == mrd_pkg::SOURCE);

	// wait counter saturates and clears outside source
	// rd_start on the cycle after saturation
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			cnt_wait    <= '0;
			wait_done_r <= 1'b0;
			rd_start    <= 1'b0;
		end
		else
		begin
			if (!in_source)
				cnt_wait <= '0;
			else if (cnt_wait != WAIT_MAX)
				cnt_wait <= cnt_wait + 1'b1;
			wait_done_r <= (cnt_wait == WAIT_MAX);
			// one pulse per frame
			rd_start    <= in_source && (cnt_wait == WAIT_MAX) && !wait_done_r;
		end
	end

	// framing one cycle behind the memory
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			mem_valid_r <= 1'b0;
			src_valid   <= 1'b0;
			src_sop     <= 1'b0;
			src_eop     <= 1'b0;
			cnt_out     <= '0;
			source_end  <= 1'b0;
		end
		else
		begin
			mem_valid_r <= mem_valid;
			if (in_source)
			begin
				src_valid <= mem_valid;
				// rising edge of mem_valid opens the frame
				src_sop   <= mem_valid && !mem_valid_r;
				// count of words already passed
				if (mem_valid)
					cnt_out <= cnt_out + 1'b1;
				src_eop   <= mem_valid && (cnt_out == (n_points - 1'b1));
			end
			else
			begin
				src_valid <= 1'b0;
				src_sop   <= 1'b0;
				src_eop   <= 1'b0;
				cnt_out   <= '0;
			end
			// closes the frame so the controller drops to idle
			source_end <= in_source && src_eop;
		end
	end

	always_ff @(posedge clk)
	begin
		src_data <= mem_data;
	end

	// address counter stops after the last word
	a_eop_valid: assert property (@(posedge clk) disable iff (!rst_n)
		src_eop |-> (src_valid && !mem_valid));

endmodule

`default_nettype wire

//--- design/mrd_pkg.sv
`default_nettype none

package mrd_pkg;

	// controller phase
	// values 2 to 4 stay free for the compute phases of the full controller
	typedef enum logic [2:0]
	{
		IDLE   = 3'd0,
		SINK   = 3'd1,
		SOURCE = 3'd5
	} mrd_state_e;

	// radix of one stage, 1 to 5
	// a radix of 1 marks an unused stage
	typedef logic [2:0] radix_t;

endpackage

`default_nettype wire

//--- design/mrd_source_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "mrd_defines.svh"

module mrd_source_top
(
	input  wire                                    clk,
	input  wire                                    rst_n,
	input  wire mrd_pkg::radix_t [0:`MRD_N_STAGE-1] nf,
	input  wire                                    sink_valid,
	input  wire                                    sink_sop,
	input  wire [`MRD_W_DATA-1:0]                  sink_data,
	output logic                                   src_valid,
	output logic                                   src_sop,
	output logic                                   src_eop,
	output logic [`MRD_W_DATA-1:0]                 src_data,
	output logic                                   source_end
);

	// controller
	mrd_pkg::mrd_state_e    state;
	logic                   cfg_load;
	logic                   wr_en;
	logic [`MRD_W_ADDR-1:0] wr_addr;
	logic [`MRD_W_DATA-1:0] wr_data;

	// address counter
	logic [`MRD_W_ADDR:0]   n_points;
	logic [`MRD_W_ADDR-1:0] rd_addr;
	logic                   rd_addr_valid;
	logic                   rd_start;

	// bank split, write and read side
	logic [`MRD_W_ROW-1:0]  wr_row;
	logic [2:0]             wr_bank;
	logic                   wr_bank_valid;
	logic [`MRD_W_ROW-1:0]  rd_row;
	logic [2:0]             rd_bank;
	logic                   rd_bank_valid;

	// memory read port
	logic                   mem_valid;
	logic [`MRD_W_DATA-1:0] mem_data;

	mrd_ctrl_fsm i_ctrl_fsm
	(
		.clk        (clk),
		.rst_n      (rst_n),
		.nf         (nf),
		.sink_valid (sink_valid),
		.sink_sop   (sink_sop),
		.sink_data  (sink_data),
		.n_points   (n_points),
		.source_end (source_end),
		.state      (state),
		.cfg_load   (cfg_load),
		.wr_en      (wr_en),
		.wr_addr    (wr_addr),
		.wr_data    (wr_data)
	);

	mrd_digit_rev_addr i_digit_rev_addr
	(
		.clk           (clk),
		.rst_n         (rst_n),
		.cfg_load      (cfg_load),
		.nf            (nf),
		.rd_start      (rd_start),
		.n_points      (n_points),
		.rd_addr       (rd_addr),
		.rd_addr_valid (rd_addr_valid)
	);

	// write side, one cycle to the memory
	mrd_divider_7 i_div_wr
	(
		.clk        (clk),
		.rst_n      (rst_n),
		.addr       (wr_addr),
		.addr_valid (wr_en),
		.row        (wr_row),
		.bank       (wr_bank),
		.bank_valid (wr_bank_valid)
	);

	mrd_divider_7 i_div_rd
	(
		.clk        (clk),
		.rst_n      (rst_n),
		.addr       (rd_addr),
		.addr_valid (rd_addr_valid),
		.row        (rd_row),
		.bank       (rd_bank),
		.bank_valid (rd_bank_valid)
	);

	mrd_bank_mem i_bank_mem
	(
		.clk       (clk),
		.rst_n     (rst_n),
		.wr_en     (wr_bank_valid),
		.wr_row    (wr_row),
		.wr_bank   (wr_bank),
		.wr_data   (wr_data),
		.rd_en     (rd_bank_valid),
		.rd_row    (rd_row),
		.rd_bank   (rd_bank),
		.mem_valid (mem_valid),
		.mem_data  (mem_data)
	);

	mrd_fsm_source i_fsm_source
	(
		.clk        (clk),
		.rst_n      (rst_n),
		.state      (state),
		.n_points   (n_points),
		.mem_valid  (mem_valid),
		.mem_data   (mem_data),
		.rd_start   (rd_start),
		.src_valid  (src_valid),
		.src_sop    (src_sop),
		.src_eop    (src_eop),
		.src_data   (src_data),
		.source_end (source_end)
	);

endmodule

`default_nettype wire

//--- include/mrd_defines.svh
`ifndef MRD_DEFINES_SVH
`define MRD_DEFINES_SVH

// sample index width
// frames up to 4096 points
`define MRD_W_ADDR 12

// one sample word
`define MRD_W_DATA 16

// sample memory banks, index n lands in bank n mod 7
`define MRD_N_BANK 7

// row address inside one bank
// 4096 / 7 rows need 10 bits
`define MRD_W_ROW 10

// radix fields nf[0] to nf[5]
`define MRD_N_STAGE 6

// idle cycles in source before the first read address
`define MRD_SRC_WAIT 4

`endif

//--- mrd_source_top.f
+incdir+include
design/mrd_pkg.sv
design/mrd_ctrl_fsm.sv
design/mrd_digit_rev_addr.sv
design/mrd_divider_7.sv
design/mrd_bank_mem.sv
design/mrd_fsm_source.sv
design/mrd_source_top.sv
tests/tb_mrd_source_top.sv

//--- tests/tb_mrd_source_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "mrd_defines.svh"

module tb_mrd_source_top;

	logic                                   clk;
	logic                                   rst_n;
	mrd_pkg::radix_t [0:`MRD_N_STAGE-1]     nf;
	logic                                   sink_valid;
	logic                                   sink_sop;
	logic [`MRD_W_DATA-1:0]                 sink_data;
	logic                                   src_valid;
	logic                                   src_sop;
	logic                                   src_eop;
	logic [`MRD_W_DATA-1:0]                 src_data;
	logic                                   source_end;

	// stimulus and reference state
	int                     seed = 73;
	string                  test_name;
	logic [`MRD_W_DATA-1:0] in_data [$];
	logic [`MRD_W_DATA-1:0] exp_q [$];
	int                     out_idx;
	int                     end_cnt;
	int                     errors;
	int                     tests_pass;
	int                     tests_fail;
	logic                   eop_d;

	mrd_source_top i_dut
	(
		.clk        (clk),
		.rst_n      (rst_n),
		.nf         (nf),
		.sink_valid (sink_valid),
		.sink_sop   (sink_sop),
		.sink_data  (sink_data),
		.src_valid  (src_valid),
		.src_sop    (src_sop),
		.src_eop    (src_eop),
		.src_data   (src_data),
		.source_end (source_end)
	);

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// output checks, sampled away from the rising edge
	always @(negedge clk)
	begin
		if (!rst_n)
		begin
			eop_d = 1'b0;
		end
		else
		begin
			if (src_valid)
			begin
				assert (out_idx < exp_q.size()) else
				begin
					$display("%s: more than %0d valid outputs", test_name, exp_q.size());
					errors++;
				end
				if (out_idx < exp_q.size())
				begin
					assert (src_data == exp_q[out_idx]) else
					begin
						$display("** Error %s: src_data[%0d] expected %h actual %h",
							test_name, out_idx, exp_q[out_idx], src_data);
						errors++;
					end
				end
				assert (src_sop == (out_idx == 0)) else
				begin
					$display("** Error %s: src_sop at output %0d expected %0b actual %0b",
						test_name, out_idx, (out_idx == 0), src_sop);
					errors++;
				end
				assert (src_eop == (out_idx == exp_q.size() - 1)) else
				begin
					$display("** Error %s: src_eop at output %0d expected %0b actual %0b",
						test_name, out_idx, (out_idx == exp_q.size() - 1), src_eop);
					errors++;
				end
				out_idx++;
			end
			else
			begin
				assert (!src_sop && !src_eop) else
				begin
					$display("%s: sop or eop seen without src_valid", test_name);
					errors++;
				end
			end
			// single pulse right behind eop
			assert (source_end == eop_d) else
			begin
				$display("** Error %s: source_end expected %0b actual %0b",
					test_name, eop_d, source_end);
				errors++;
			end
			if (source_end)
				end_cnt++;
			eop_d = src_valid && src_eop;
		end
	end

	task automatic apply_reset();
		rst_n      = 1'b0;
		sink_valid = 1'b0;
		sink_sop   = 1'b0;
		sink_data  = '0;
		repeat (3) @(posedge clk);
		#2;
		rst_n = 1'b1;
	endtask

	// expected order straight from the digit rule, c0 fastest
	task automatic build_expected(input mrd_pkg::radix_t [0:`MRD_N_STAGE-1] cfg, input int n);
		int digit [`MRD_N_STAGE];
		int stride [`MRD_N_STAGE];
		int addr;
		stride[`MRD_N_STAGE-1] = 1;
		for (int k = `MRD_N_STAGE - 2; k >= 0; k--)
			stride[k] = stride[k+1] * cfg[k+1];
		for (int k = 0; k < `MRD_N_STAGE; k++)
			digit[k] = 0;
		exp_q.delete();
		for (int j = 0; j < n; j++)
		begin
			addr = 0;
			for (int k = 0; k < `MRD_N_STAGE; k++)
				addr += digit[k] * stride[k];
			exp_q.push_back(in_data[addr]);
			// counter step with carry
			for (int k = 0; k < `MRD_N_STAGE; k++)
			begin
				digit[k]++;
				if (digit[k] < cfg[k])
					break;
				digit[k] = 0;
			end
		end
	endtask

	// one whole frame, sink then source
	task automatic run_frame(input string name, input mrd_pkg::radix_t [0:`MRD_N_STAGE-1] cfg,
		input bit gapped, input bit junk_in_source);
		int          n;
		int          gap;
		int          cycles;
		int          limit;
		int          err_start;
		logic [31:0] rnd;
		test_name = name;
		err_start = errors;
		n = 1;
		for (int k = 0; k < `MRD_N_STAGE; k++)
			n = n * cfg[k];
		in_data.delete();
		for (int i = 0; i < n; i++)
		begin
			rnd = $random(seed);
			in_data.push_back(rnd[`MRD_W_DATA-1:0]);
		end
		build_expected(cfg, n);
		out_idx = 0;
		end_cnt = 0;
		nf      = cfg;
		// natural order into the sink
		for (int i = 0; i < n; i++)
		begin
			gap = gapped ? ($random(seed) & 3) : 0;
			for (int g = 0; g < gap; g++)
			begin
				sink_valid = 1'b0;
				sink_sop   = 1'b0;
				@(posedge clk);
				#2;
			end
			sink_valid = 1'b1;
			sink_sop   = (i == 0);
			sink_data  = in_data[i];
			@(posedge clk);
			#2;
		end
		sink_valid = 1'b0;
		sink_sop   = 1'b0;
		// controller is in source now, these must not land anywhere
		if (junk_in_source)
		begin
			for (int i = 0; i < 6; i++)
			begin
				rnd        = $random(seed);
				sink_valid = 1'b1;
				sink_sop   = (i == 0);
				sink_data  = rnd[`MRD_W_DATA-1:0];
				@(posedge clk);
				#2;
			end
			sink_valid = 1'b0;
			sink_sop   = 1'b0;
		end
		// wait for the frame to close
		limit  = 3 * n + 64;
		cycles = 0;
		while ((end_cnt == 0) && (cycles < limit))
		begin
			@(posedge clk);
			#2;
			cycles++;
		end
		if (end_cnt == 0)
		begin
			$display("%s: timeout, no source_end within %0d cycles", name, limit);
			errors++;
			apply_reset();
		end
		else
		begin
			assert (out_idx == n) else
			begin
				$display("** Error %s: output count expected %0d actual %0d", name, n, out_idx);
				errors++;
			end
		end
		if (errors == err_start)
		begin
			tests_pass++;
			$display("test %-16s ok, %0d points", name, n);
		end
		else
		begin
			tests_fail++;
			$display("test %-16s FAILED, %0d errors", name, errors - err_start);
		end
	endtask

	initial
	begin
		errors     = 0;
		tests_pass = 0;
		tests_fail = 0;
		out_idx    = 0;
		end_cnt    = 0;
		eop_d      = 1'b0;
		test_name  = "reset";
		nf         = {`MRD_N_STAGE{3'd1}};
		apply_reset();
		run_frame("single_radix", {3'd5, 3'd1, 3'd1, 3'd1, 3'd1, 3'd1}, 1'b0, 1'b0);
		run_frame("bit_reverse", {3'd2, 3'd2, 3'd2, 3'd2, 3'd1, 3'd1}, 1'b0, 1'b0);
		run_frame("mixed_radix", {3'd3, 3'd4, 3'd5, 3'd1, 3'd1, 3'd1}, 1'b0, 1'b0);
		run_frame("framing", {3'd4, 3'd3, 3'd1, 3'd1, 3'd1, 3'd1}, 1'b0, 1'b0);
		run_frame("gapped_sink", {3'd5, 3'd3, 3'd2, 3'd1, 3'd1, 3'd1}, 1'b1, 1'b1);
		// second frame opens on the cycle after source_end
		run_frame("back_to_back", {3'd2, 3'd3, 3'd4, 3'd1, 3'd1, 3'd1}, 1'b0, 1'b0);
		run_frame("max_rows_1024", {3'd4, 3'd4, 3'd4, 3'd4, 3'd4, 3'd1}, 1'b0, 1'b0);
		// stray outputs after the last frame
		repeat (8) @(posedge clk);
		#2;
		$display("tests passed %0d, failed %0d, errors %0d", tests_pass, tests_fail, errors);
		if ((tests_fail == 0) && (errors == 0))
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire
